// ==== flist.f ====
+incdir+include
source/otp_buf_store_pkg.sv
source/otp_buf_ctrl_pkg.sv
source/otp_part_loader.sv
source/otp_ecc_reg.sv
source/otp_part_checker.sv
source/otp_part_buf_top.sv
test/tb_otp_part_buf.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the partition buffer testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tb_otp_part_buf \
  -Mdir obj_dir \
  -o sim_otp_part_buf

./obj_dir/sim_otp_part_buf | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi

// ==== test/tb_otp_part_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_params.svh"

module tb_otp_part_buf;

  // The tests need a few hundred cycles, so this leaves a wide margin.
  localparam int MaxCycles = 2000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          beat_valid_i;
  otp_buf_ctrl_pkg::otp_beat_t   beat_i;
  logic                          beat_ready_o;
  otp_buf_store_pkg::otp_addr_t  rd_addr_i;
  otp_buf_store_pkg::otp_word_t  rdata_o;
  logic                          part_full_o;
  logic                          ecc_err_o;
  logic                          status_valid_o;
  otp_buf_ctrl_pkg::otp_status_t status_o;
  logic                          status_ready_i;

  // Expected contents of the partition.
  otp_buf_store_pkg::otp_word_t words [`OTP_DEPTH];
  int cyc = 0;
  int load_end = 0;

  otp_part_buf_top otp_part_buf_top_inst (.*);

  always #10 clk_i = ~clk_i;

  // Run length guard.
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (cyc >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles.", MaxCycles);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string name);
    if (act !== exp) begin
      $display("FAIL time=%0t %s: got %h, expected %h", $time, name, act, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // No corruption source exists, so the ECC flag must stay low all run.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_eq(64'(ecc_err_o), 64'd0, "ecc_err_o");
    end
  end

  // Reference fold: rotate left by one, then XOR the next word.
  function automatic otp_buf_store_pkg::otp_word_t digest_model();
    otp_buf_store_pkg::otp_word_t d;
    d = '0;
    for (int i = 0; i < `OTP_DEPTH - 1; i++) begin
      d = {d[`OTP_WIDTH-2:0], d[`OTP_WIDTH-1]} ^ words[i];
    end
    return d;
  endfunction

  // Inputs change 2 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic send_beat(input otp_buf_ctrl_pkg::otp_op_e op,
                           input otp_buf_store_pkg::otp_word_t word);
    beat_valid_i = 1'b1;
    beat_i.op    = op;
    beat_i.word  = word;
    // Ready is sampled mid-cycle; the transfer happens on the next edge.
    do @(negedge clk_i); while (!beat_ready_o);
    next_cycle();
    beat_valid_i = 1'b0;
  endtask

  // Fills words 0 to 14 at random, word 15 with a good or broken digest.
  task automatic load_part(input logic good);
    for (int i = 0; i < `OTP_DEPTH - 1; i++) begin
      words[i] = {$urandom, $urandom};
    end
    words[`OTP_DEPTH-1] = good ? digest_model() : (digest_model() ^ 64'h1);
    for (int i = 0; i < `OTP_DEPTH; i++) begin
      send_beat(otp_buf_ctrl_pkg::OP_DATA, words[i]);
    end
    load_end = cyc;
  endtask

  task automatic read_all();
    for (int a = 0; a < `OTP_DEPTH; a++) begin
      rd_addr_i = otp_buf_store_pkg::otp_addr_t'(a);
      @(negedge clk_i);
      check_eq(rdata_o, words[a], $sformatf("rdata_o[%0d]", a));
      next_cycle();
    end
  endtask

  // Status must rise within 16 cycles of the last write.
  task automatic wait_status();
    forever begin
      @(negedge clk_i);
      if (status_valid_o) break;
      if (cyc - load_end >= 16) begin
        $display("Error: status_valid_o did not rise within 16 cycles of the load.");
        $display("TESTS FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic accept_status();
    next_cycle();
    status_ready_i = 1'b1;
    next_cycle();
    status_ready_i = 1'b0;
    @(negedge clk_i);
    check_eq(64'(status_valid_o), 64'd0, "status_valid_o");
    next_cycle();
  endtask

  task automatic test_reset();
    check_eq(64'(status_valid_o), 64'd0, "status_valid_o");
    check_eq(64'(part_full_o), 64'd0, "part_full_o");
    check_eq(64'(beat_ready_o), 64'd1, "beat_ready_o");
    check_eq(64'(ecc_err_o), 64'd0, "ecc_err_o");
    for (int i = 0; i < `OTP_DEPTH; i++) begin
      words[i] = '0;
    end
    read_all();
  endtask

  task automatic test_load_readback();
    load_part(1'b1);
    @(negedge clk_i);
    check_eq(64'(part_full_o), 64'd1, "part_full_o");
    next_cycle();
    read_all();
  endtask

  task automatic test_digest_match();
    wait_status();
    check_eq(64'(status_o.digest_ok), 64'd1, "status_o.digest_ok");
    check_eq(64'(status_o.ecc_err), 64'd0, "status_o.ecc_err");
    accept_status();
  endtask

  task automatic test_mismatch_backpressure();
    otp_buf_ctrl_pkg::otp_status_t held;
    send_beat(otp_buf_ctrl_pkg::OP_RESTART, '0);
    load_part(1'b0);
    wait_status();
    held = status_o;
    check_eq(64'(held.digest_ok), 64'd0, "status_o.digest_ok");
    // Ready stays low, so valid and the result must hold.
    repeat (10) begin
      @(negedge clk_i);
      check_eq(64'(status_valid_o), 64'd1, "status_valid_o");
      check_eq(64'(status_o), 64'(held), "status_o");
    end
    accept_status();
  endtask

  task automatic test_full_restart();
    check_eq(64'(part_full_o), 64'd1, "part_full_o");
    // Data beats while full are dropped.
    repeat (3) begin
      send_beat(otp_buf_ctrl_pkg::OP_DATA, {$urandom, $urandom});
    end
    read_all();
    send_beat(otp_buf_ctrl_pkg::OP_RESTART, '0);
    @(negedge clk_i);
    check_eq(64'(part_full_o), 64'd0, "part_full_o");
    next_cycle();
    load_part(1'b1);
    wait_status();
    check_eq(64'(status_o.digest_ok), 64'd1, "status_o.digest_ok");
    // A restart drops the status that is still waiting for ready.
    next_cycle();
    send_beat(otp_buf_ctrl_pkg::OP_RESTART, '0);
    @(negedge clk_i);
    check_eq(64'(status_valid_o), 64'd0, "status_valid_o");
    check_eq(64'(part_full_o), 64'd0, "part_full_o");
    next_cycle();
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    beat_valid_i   = 1'b0;
    beat_i         = '0;
    rd_addr_i      = '0;
    status_ready_i = 1'b0;
    void'($urandom(32'h1722b186));
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    test_reset();
    test_load_readback();
    test_digest_match();
    test_mismatch_backpressure();
    test_full_restart();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/otp_part_buf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_params.svh"

// Buffered OTP partition.
// Loader fills the register file, checker verifies the stored digest.
module otp_part_buf_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          beat_valid_i,
  input  otp_buf_ctrl_pkg::otp_beat_t   beat_i,
  output logic                          beat_ready_o,
  input  otp_buf_store_pkg::otp_addr_t  rd_addr_i,
  output otp_buf_store_pkg::otp_word_t  rdata_o,
  output logic                          part_full_o,
  output logic                          ecc_err_o,
  output logic                          status_valid_o,
  output otp_buf_ctrl_pkg::otp_status_t status_o,
  input  logic                          status_ready_i
);

  otp_buf_store_pkg::otp_wr_t                    wr;
  otp_buf_store_pkg::otp_word_t [`OTP_DEPTH-1:0] data;
  logic                                          full;
  logic                                          restart;

  // Producer.
  otp_part_loader otp_part_loader_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_valid_i (beat_valid_i),
    .beat_i       (beat_i),
    .beat_ready_o (beat_ready_o),
    .rd_addr_i    (rd_addr_i),
    .wr_o         (wr),
    .full_o       (full),
    .restart_o    (restart),
    .part_full_o  (part_full_o)
  );

  // Buffer.
  otp_ecc_reg otp_ecc_reg_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (wr),
    .rdata_o   (rdata_o),
    .data_o    (data),
    .ecc_err_o (ecc_err_o)
  );

  // Consumer.
  otp_part_checker otp_part_checker_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .full_i         (full),
    .restart_i      (restart),
    .data_i         (data),
    .ecc_err_i      (ecc_err_o),
    .status_valid_o (status_valid_o),
    .status_o       (status_o),
    .status_ready_i (status_ready_i)
  );

endmodule

`default_nettype wire

// ==== source/otp_part_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_params.svh"

// Integrity checker of a full partition.
// Folds words 0 to 14 into a digest and compares it with word 15.
module otp_part_checker (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          full_i,
  input  logic                                          restart_i,
  input  otp_buf_store_pkg::otp_word_t [`OTP_DEPTH-1:0] data_i,
  input  logic                                          ecc_err_i,
  output logic                                          status_valid_o,
  output otp_buf_ctrl_pkg::otp_status_t                 status_o,
  input  logic                                          status_ready_i
);

  // Last folded word and position of the stored digest.
  localparam otp_buf_store_pkg::otp_addr_t LastIdx =
    otp_buf_store_pkg::otp_addr_t'(`OTP_DEPTH - 2);
  localparam int DigestIdx = `OTP_DEPTH - 1;

  otp_buf_ctrl_pkg::checker_state_e state_q, state_d;
  otp_buf_store_pkg::otp_addr_t     idx_q, idx_d;
  logic                             sticky_q, sticky_d;
  otp_buf_ctrl_pkg::otp_status_t    status_q, status_d;
  otp_buf_store_pkg::otp_word_t     digest_q, digest_d;
  otp_buf_store_pkg::otp_word_t     digest_next;

  // Rotate left by one, then fold in the current word.
  assign digest_next = {digest_q[`OTP_WIDTH-2:0], digest_q[`OTP_WIDTH-1]} ^ data_i[idx_q];

  always_comb begin
    state_d  = state_q;
    idx_d    = idx_q;
    sticky_d = sticky_q;
    status_d = status_q;
    digest_d = digest_q;
    unique case (state_q)
      otp_buf_ctrl_pkg::ST_IDLE: begin
        if (full_i) begin
          state_d  = otp_buf_ctrl_pkg::ST_SCAN;
          idx_d    = '0;
          sticky_d = 1'b0;
          digest_d = '0;
        end
      end
      otp_buf_ctrl_pkg::ST_SCAN: begin
        // One word per cycle.
        digest_d = digest_next;
        idx_d    = idx_q + 1'b1;
        sticky_d = sticky_q | ecc_err_i;
        if (idx_q == LastIdx) begin
          state_d            = otp_buf_ctrl_pkg::ST_REPORT;
          // Result is frozen here so it holds under back-pressure.
          status_d.digest_ok = (digest_next == data_i[DigestIdx]);
          status_d.ecc_err   = sticky_q | ecc_err_i;
        end
      end
      otp_buf_ctrl_pkg::ST_REPORT: begin
        if (status_ready_i) begin
          state_d = otp_buf_ctrl_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = otp_buf_ctrl_pkg::ST_IDLE;
      end
    endcase
    // Restart drops any scan or pending status.
    if (restart_i) begin
      state_d = otp_buf_ctrl_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= otp_buf_ctrl_pkg::ST_IDLE;
      idx_q    <= '0;
      sticky_q <= 1'b0;
      status_q <= '0;
    end else begin
      state_q  <= state_d;
      idx_q    <= idx_d;
      sticky_q <= sticky_d;
      status_q <= status_d;
    end
  end

  always_ff @(posedge clk_i) begin
    digest_q <= digest_d;
  end

  assign status_valid_o = (state_q == otp_buf_ctrl_pkg::ST_REPORT);
  assign status_o       = status_q;

  // Stalled status holds until accepted, unless a restart drops it.
  a_status_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (status_valid_o && !status_ready_i && !restart_i)
      |=> (status_valid_o && $stable(status_o))
  );

endmodule

`default_nettype wire

// ==== source/otp_ecc_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_params.svh"

// Register file of one buffered partition.
// Each word carries per-byte parity, checked on all words at once.
module otp_ecc_reg (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  otp_buf_store_pkg::otp_wr_t                    wr_i,
  output otp_buf_store_pkg::otp_word_t                  rdata_o,
  output otp_buf_store_pkg::otp_word_t [`OTP_DEPTH-1:0] data_o,
  output logic                                          ecc_err_o
);

  // Even parity of each byte of a word.
  function automatic otp_buf_store_pkg::otp_ecc_t byte_parity(
    input otp_buf_store_pkg::otp_word_t word
  );
    otp_buf_store_pkg::otp_ecc_t par;
    for (int i = 0; i < `OTP_ECC_W; i++) begin
      par[i] = ^word[8*i +: 8];
    end
    return par;
  endfunction

  otp_buf_store_pkg::otp_word_t [`OTP_DEPTH-1:0] data_q, data_d;
  otp_buf_store_pkg::otp_ecc_t  [`OTP_DEPTH-1:0] ecc_q, ecc_d;
  otp_buf_store_pkg::otp_ecc_t                   ecc_enc;
  logic                         [`OTP_DEPTH-1:0] err;

  // Single encoder on the write data.
  assign ecc_enc = byte_parity(wr_i.wdata);

  // Host read is combinational.
  assign rdata_o = data_q[wr_i.addr];

  always_comb begin
    data_d = data_q;
    ecc_d  = ecc_q;
    if (wr_i.wren) begin
      data_d[wr_i.addr] = wr_i.wdata;
      ecc_d[wr_i.addr]  = ecc_enc;
    end
  end

  // All-zero word with all-zero parity is a valid codeword.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
      ecc_q  <= '0;
    end else begin
      data_q <= data_d;
      ecc_q  <= ecc_d;
    end
  end

  // Whole partition is visible to the checker.
  assign data_o = data_q;

  // One parity check per stored word.
  for (genvar k = 0; k < `OTP_DEPTH; k++) begin : gen_ecc_chk
    // Any byte whose parity disagrees flags the word.
    assign err[k] = |(byte_parity(data_q[k]) ^ ecc_q[k]);
  end

  assign ecc_err_o = |err;

  // Storage never holds unknown bits once out of reset.
  a_data_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(data_q)
  );

  a_ecc_err_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(ecc_err_o)
  );

endmodule

`default_nettype wire

// ==== source/otp_part_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_params.svh"

// Partition loader.
// Writes incoming words in order, then hands the address port to host reads.
module otp_part_loader (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         beat_valid_i,
  input  otp_buf_ctrl_pkg::otp_beat_t  beat_i,
  output logic                         beat_ready_o,
  input  otp_buf_store_pkg::otp_addr_t rd_addr_i,
  output otp_buf_store_pkg::otp_wr_t   wr_o,
  output logic                         full_o,
  output logic                         restart_o,
  output logic                         part_full_o
);

  // Address of the digest word, the last one written.
  localparam otp_buf_store_pkg::otp_addr_t LastAddr =
    otp_buf_store_pkg::otp_addr_t'(`OTP_DEPTH - 1);

  otp_buf_ctrl_pkg::loader_state_e state_q, state_d;
  otp_buf_store_pkg::otp_addr_t    ptr_q, ptr_d;
  logic                            full_q, full_d;
  logic                            accept;
  logic                            take_data;
  logic                            take_restart;

  // Beats are never stalled.
  assign beat_ready_o = 1'b1;
  assign accept       = beat_valid_i & beat_ready_o;
  assign take_data    = accept & (beat_i.op == otp_buf_ctrl_pkg::OP_DATA);
  assign take_restart = accept & (beat_i.op == otp_buf_ctrl_pkg::OP_RESTART);

  // Data beats arriving while full are accepted and dropped.
  always_comb begin
    wr_o.wren  = take_data & (state_q == otp_buf_ctrl_pkg::ST_LOAD);
    // Host address only reaches the buffer once loading is done.
    wr_o.addr  = (state_q == otp_buf_ctrl_pkg::ST_LOAD) ? ptr_q : rd_addr_i;
    wr_o.wdata = beat_i.word;
  end

  always_comb begin
    state_d = state_q;
    ptr_d   = ptr_q;
    full_d  = 1'b0;
    if (take_restart) begin
      // Rewind in either state.
      state_d = otp_buf_ctrl_pkg::ST_LOAD;
      ptr_d   = '0;
    end else if (wr_o.wren) begin
      ptr_d = ptr_q + 1'b1;
      if (ptr_q == LastAddr) begin
        state_d = otp_buf_ctrl_pkg::ST_FULL;
        full_d  = 1'b1;
        ptr_d   = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= otp_buf_ctrl_pkg::ST_LOAD;
      ptr_q   <= '0;
      full_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      ptr_q   <= ptr_d;
      full_q  <= full_d;
    end
  end

  // Full pulse follows the last write by one cycle.
  assign full_o = full_q;
  // Restart pulse lines up with the accepting edge.
  assign restart_o   = take_restart;
  assign part_full_o = (state_q == otp_buf_ctrl_pkg::ST_FULL);

  // The full state is entered only after the digest word is written.
  // The full pulse comes with it.
  a_full_after_last_write : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(part_full_o) |-> (full_o && $past(wr_o.wren && (wr_o.addr == LastAddr)))
  );

endmodule

`default_nettype wire

// ==== source/otp_buf_ctrl_pkg.sv ====
`default_nettype none

// Control types for the partition loader and the digest checker.
package otp_buf_ctrl_pkg;

  // Beat opcode.
  // OP_DATA writes the next word, OP_RESTART empties the partition.
  typedef enum logic [0:0] {
    OP_DATA    = 1'b0,
    OP_RESTART = 1'b1
  } otp_op_e;

  // Input beat from the OTP read path, 65 bits.
  typedef struct packed {
    otp_op_e                      op;
    otp_buf_store_pkg::otp_word_t word;
  } otp_beat_t;

  // Integrity result of one partition scan.
  typedef struct packed {
    logic digest_ok;
    logic ecc_err;
  } otp_status_t;

  // Loader FSM.
  typedef enum logic [0:0] {
    ST_LOAD,
    ST_FULL
  } loader_state_e;

  // Checker FSM.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_REPORT
  } checker_state_e;

endpackage

`default_nettype wire

// ==== source/otp_buf_store_pkg.sv ====
`default_nettype none

`include "otp_buf_params.svh"

// Storage types shared by the loader and the register file.
package otp_buf_store_pkg;

  // One partition word as read from the OTP macro.
  typedef logic [`OTP_WIDTH-1:0] otp_word_t;

  // Check bits of one word.
  // Bit i is the even parity of byte i.
  typedef logic [`OTP_ECC_W-1:0] otp_ecc_t;

  // Word address inside the partition.
  typedef logic [`OTP_AW-1:0] otp_addr_t;

  // Write port into the register file.
  // In the full state the address carries the host read address.
  typedef struct packed {
    logic      wren;
    otp_addr_t addr;
    otp_word_t wdata;
  } otp_wr_t;

endpackage

`default_nettype wire

// ==== include/otp_buf_params.svh ====
`ifndef OTP_BUF_PARAMS_SVH
`define OTP_BUF_PARAMS_SVH

// Partition geometry, fixed design-wide.
// The check-bit layout assumes one parity bit per byte of a 64-bit word.

// Bits per OTP word.
`define OTP_WIDTH 64

// Words per buffered partition.
// The last word holds the stored digest.
`define OTP_DEPTH 16

// Address bits, enough for OTP_DEPTH words.
`define OTP_AW 4

// Check bits per word, one per byte.
`define OTP_ECC_W 8

`endif
